//--- surf5_id_ctrl.f
verilog/surf5_bus_pkg.sv
verilog/surf5_led_pkg.sv
verilog/surf5_reg_decode.sv
verilog/surf5_irq_regs.sv
verilog/surf5_led_regs.sv
verilog/led_charlieplexer.sv
verilog/surf5_id_ctrl.sv
verification/surf5_id_ctrl_tb.sv

//--- verification/surf5_id_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module surf5_id_ctrl_tb;

    localparam logic [31:0] FW_VERSION  = 32'h0105_0A00;
    localparam int unsigned DWELL       = 3;
    localparam int          ACK_TIMEOUT = 20;
    // Device ID is the ASCII text S5A7
    localparam logic [31:0] EXP_ID      = "S5A7";

    logic                     clk_i = 1'b0;
    logic                     rst_i;
    surf5_bus_pkg::wb_req_t   bus_i;
    surf5_bus_pkg::wb_rsp_t   bus_o;
    surf5_bus_pkg::wb_word_t  interrupt_i;
    surf5_led_pkg::led_vec_t  internal_led_i;
    logic                     irq_o;
    logic                     soft_rst_o;
    logic                     sst_sel_o;
    logic                     sst_sel_oe_o;
    logic                     local_osc_en_o;
    logic                     cs_b_o;
    logic                     fp_led_o;
    surf5_led_pkg::led_pins_t led_pin_o;
    surf5_led_pkg::led_pins_t led_pin_oe_o;

    integer seed;
    int     value_errs;
    int     protocol_errs;
    int     timeout_errs;

    // Pin pairs per slot, lower pin first
    int pair_a [6] = '{0, 0, 1, 2, 1, 0};
    int pair_b [6] = '{1, 2, 2, 3, 3, 3};

    surf5_id_ctrl #(
        .FIRMWARE_VERSION(FW_VERSION),
        .SLOT_DWELL(DWELL)
    ) surf5_id_ctrl_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .bus_i          (bus_i),
        .bus_o          (bus_o),
        .interrupt_i    (interrupt_i),
        .internal_led_i (internal_led_i),
        .irq_o          (irq_o),
        .soft_rst_o     (soft_rst_o),
        .sst_sel_o      (sst_sel_o),
        .sst_sel_oe_o   (sst_sel_oe_o),
        .local_osc_en_o (local_osc_en_o),
        .cs_b_o         (cs_b_o),
        .fp_led_o       (fp_led_o),
        .led_pin_o      (led_pin_o),
        .led_pin_oe_o   (led_pin_oe_o)
    );

    // 100 ns period
    always #50 clk_i = ~clk_i;

    //////////////////////////////////////////////////////////////////////
    // Protocol properties
    //////////////////////////////////////////////////////////////////////
    ack_under_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_o.ack |-> bus_i.cyc)
        else begin
            $display("Bus ack seen without cyc");
            protocol_errs++;
        end

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
        bus_o.ack |=> !bus_o.ack)
        else begin
            $display("Bus ack held longer than one cycle");
            protocol_errs++;
        end

    // Charlieplex pins only ever enabled two at a time
    led_pin_pairs: assert property (@(posedge clk_i) disable iff (rst_i)
        ($countones(led_pin_oe_o) == 0) || ($countones(led_pin_oe_o) == 2))
        else begin
            $display("LED pin enables not a pair");
            protocol_errs++;
        end

    //////////////////////////////////////////////////////////////////////
    // Bus and check tasks
    //////////////////////////////////////////////////////////////////////
    task automatic bus_cycle(input logic we, input surf5_bus_pkg::wb_addr_t adr,
                             input surf5_bus_pkg::wb_word_t wdat,
                             output surf5_bus_pkg::wb_word_t rdat);
        int   waited;
        logic got_ack;
        waited  = 0;
        got_ack = 1'b0;
        rdat    = '0;
        @(posedge clk_i);
        bus_i <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        // Sample on the falling edge, well clear of updates
        while (!got_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk_i);
            if (bus_o.ack) begin
                rdat    = bus_o.dat;
                got_ack = 1'b1;
            end
            waited++;
        end
        if (!got_ack) begin
            $display("No ack within %0d cycles for address 0x%h", ACK_TIMEOUT, adr);
            timeout_errs++;
        end
        // Write commits on this edge
        @(posedge clk_i);
        bus_i <= '0;
    endtask

    task automatic write_reg(input surf5_bus_pkg::wb_addr_t adr,
                             input surf5_bus_pkg::wb_word_t dat);
        surf5_bus_pkg::wb_word_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input surf5_bus_pkg::wb_addr_t adr,
                            output surf5_bus_pkg::wb_word_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    // Master drops cyc after one cycle, before the slave answers
    task automatic abort_write(input surf5_bus_pkg::wb_addr_t adr,
                               input surf5_bus_pkg::wb_word_t wdat);
        @(posedge clk_i);
        bus_i <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: wdat};
        @(posedge clk_i);
        bus_i <= '0;
        @(negedge clk_i);
        compare_word("ack after abort", bus_o.ack, 0);
        @(posedge clk_i);
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp);
            value_errs++;
        end
    endtask

    // Expected drive for LED k, from the pair table
    function automatic void slot_pins(input int k, output logic [3:0] pin,
                                      output logic [3:0] oe);
        int hi;
        int lo;
        hi  = (k < 6) ? pair_a[k % 6] : pair_b[k % 6];
        lo  = (k < 6) ? pair_b[k % 6] : pair_a[k % 6];
        pin = 4'b0001 << hi;
        oe  = (4'b0001 << hi) | (4'b0001 << lo);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    surf5_bus_pkg::wb_word_t rd;
    surf5_bus_pkg::wb_word_t v_reset;
    surf5_bus_pkg::wb_word_t v_clk;
    surf5_bus_pkg::wb_word_t v_ss;
    surf5_bus_pkg::wb_word_t irq_val;
    surf5_bus_pkg::wb_word_t mask;
    surf5_bus_pkg::wb_word_t led_wr;
    surf5_bus_pkg::wb_word_t led_exp;
    logic [11:0]             ovr;
    logic [3:0]              exp_pin;
    logic [3:0]              exp_oe;
    int                      lit;

    initial begin
        seed           = 32'h80986f47;
        value_errs     = 0;
        protocol_errs  = 0;
        timeout_errs   = 0;
        rst_i          = 1'b1;
        bus_i          = '0;
        interrupt_i    = '0;
        internal_led_i = '0;
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        compare_word("irq_o", irq_o, 0);
        compare_word("cs_b_o", cs_b_o, 1);
        compare_word("led_pin_oe_o", led_pin_oe_o, 0);

        // ID, version and an unmapped slot
        read_reg(16'h0000, rd);
        compare_word("device_id", rd, EXP_ID);
        read_reg(16'h0004, rd);
        compare_word("version", rd, FW_VERSION);
        read_reg(16'h002C, rd);
        compare_word("unmapped 0x2C", rd, 0);

        // Control registers, a few random rounds
        repeat (4) begin
            v_reset = $random(seed);
            v_clk   = $random(seed);
            v_ss    = $random(seed);
            write_reg(16'h0014, v_reset);
            write_reg(16'h001C, v_clk);
            write_reg(16'h0024, v_ss);
            @(negedge clk_i);
            compare_word("soft_rst_o", soft_rst_o, v_reset[0]);
            compare_word("sst_sel_o", sst_sel_o, v_clk[0]);
            compare_word("sst_sel_oe_o", sst_sel_oe_o, v_clk[1]);
            compare_word("local_osc_en_o", local_osc_en_o, v_clk[2]);
            compare_word("cs_b_o", cs_b_o, !v_ss[0]);
            read_reg(16'h0014, rd);
            compare_word("reset reg", rd, v_reset);
            read_reg(16'h001C, rd);
            compare_word("clocksel reg", rd, v_clk);
            read_reg(16'h0024, rd);
            compare_word("spiss reg", rd, v_ss);
        end

        // Aborted write gets no ack and leaves the register alone
        abort_write(16'h0014, ~v_reset);
        read_reg(16'h0014, rd);
        compare_word("reset reg after abort", rd, v_reset);

        // Interrupt status and mask
        irq_val = $random(seed) | 32'h1;
        @(posedge clk_i);
        interrupt_i <= irq_val;
        read_reg(16'h0008, rd);
        compare_word("int_sr", rd, irq_val);
        mask = $random(seed);
        write_reg(16'h000C, mask);
        @(negedge clk_i);
        compare_word("irq_o random mask", irq_o, |(irq_val & ~mask));
        read_reg(16'h000C, rd);
        compare_word("int_mask", rd, mask);
        write_reg(16'h000C, 32'hFFFF_FFFF);
        @(negedge clk_i);
        compare_word("irq_o full mask", irq_o, 0);
        write_reg(16'h000C, 32'h0);
        @(negedge clk_i);
        compare_word("irq_o no mask", irq_o, 1);

        // LED override, LEDs 4 to 7 left free
        ovr         = 12'hF0F;
        led_wr      = $random(seed);
        led_wr[27:16] = ovr;
        led_wr[12]  = 1'b1;
        // Overridden LED 1 held dark, so a pulse on it would show
        led_wr[1]   = 1'b0;
        write_reg(16'h0018, led_wr);
        led_exp        = led_wr;
        led_exp[11:0]  = led_wr[11:0] & ovr;
        read_reg(16'h0018, rd);
        compare_word("led reg", rd, led_exp);
        compare_word("fp_led_o", fp_led_o, 1);
        // Pulse free LED 5 and overridden LED 1
        @(posedge clk_i);
        internal_led_i <= 12'h022;
        @(posedge clk_i);
        internal_led_i <= '0;
        led_exp[11:0] = led_exp[11:0] | (12'h022 & ~ovr);
        repeat (3) begin
            read_reg(16'h0018, rd);
            compare_word("led reg sticky", rd, led_exp);
        end
        led_wr[12] = 1'b0;
        write_reg(16'h0018, led_wr);
        led_exp       = led_wr;
        led_exp[11:0] = led_wr[11:0] & ovr;
        read_reg(16'h0018, rd);
        compare_word("led reg rewrite", rd, led_exp);
        compare_word("fp_led_o", fp_led_o, 0);

        // Scan, one LED at a time
        for (int k = 0; k < 12; k++) begin
            write_reg(16'h0018, {4'h0, 12'hFFF, 4'h0, 12'h001 << k});
            slot_pins(k, exp_pin, exp_oe);
            lit = 0;
            // Pins lag the state by one register
            @(posedge clk_i);
            repeat (12 * DWELL) begin
                @(negedge clk_i);
                if (led_pin_oe_o != '0) begin
                    compare_word($sformatf("led_pin_oe_o slot %0d", k), led_pin_oe_o, exp_oe);
                    compare_word($sformatf("led_pin_o slot %0d", k), led_pin_o, exp_pin);
                    lit++;
                end
            end
            compare_word($sformatf("lit cycles slot %0d", k), lit, DWELL);
        end

        // All dark
        write_reg(16'h0018, {4'h0, 12'hFFF, 16'h0});
        @(posedge clk_i);
        repeat (12 * DWELL + 2) begin
            @(negedge clk_i);
            compare_word("led_pin_oe_o dark", led_pin_oe_o, 0);
        end

        repeat (2) @(posedge clk_i);
        $display("Errors: value %0d, protocol %0d, timeout %0d",
                 value_errs, protocol_errs, timeout_errs);
        if (value_errs + protocol_errs + timeout_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/led_charlieplexer.sv
`timescale 1ns/1ps
`default_nettype none

module led_charlieplexer #(
    parameter int unsigned SLOT_DWELL = 1
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  surf5_led_pkg::led_vec_t   led_state_i,
    output surf5_led_pkg::led_pins_t  led_pin_o,
    output surf5_led_pkg::led_pins_t  led_pin_oe_o
);

    localparam int DWELL_W = (SLOT_DWELL > 1) ? $clog2(SLOT_DWELL) : 1;

    logic [DWELL_W-1:0]   dwell_cnt;
    logic                 dwell_done;
    surf5_led_pkg::slot_t slot_cnt;
    logic [1:0]           hi_pin;
    logic [1:0]           lo_pin;

    //////////////////////////////////////////////////////////////////////
    // Slot counter
    //////////////////////////////////////////////////////////////////////
    assign dwell_done = (dwell_cnt == DWELL_W'(SLOT_DWELL - 1));

    // Wrap after the last slot
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dwell_cnt <= '0;
            slot_cnt  <= '0;
        end else if (dwell_done) begin
            dwell_cnt <= '0;
            if (slot_cnt == surf5_led_pkg::slot_t'(surf5_led_pkg::LED_SLOTS - 1)) begin
                slot_cnt <= '0;
            end else begin
                slot_cnt <= slot_cnt + 4'd1;
            end
        end else begin
            dwell_cnt <= dwell_cnt + 1'b1;
        end
    end

    // Pin pair for the current slot
    assign hi_pin = surf5_led_pkg::LED_SLOT_HI[slot_cnt];
    assign lo_pin = surf5_led_pkg::LED_SLOT_LO[slot_cnt];

    //////////////////////////////////////////////////////////////////////
    // Pin drive
    //////////////////////////////////////////////////////////////////////
    // Two pins enabled when lit, all floating otherwise
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_pin_o    <= '0;
            led_pin_oe_o <= '0;
        end else if (led_state_i[slot_cnt]) begin
            led_pin_o    <= surf5_led_pkg::led_pins_t'(1) << hi_pin;
            led_pin_oe_o <= (surf5_led_pkg::led_pins_t'(1) << hi_pin)
                          | (surf5_led_pkg::led_pins_t'(1) << lo_pin);
        end else begin
            led_pin_o    <= '0;
            led_pin_oe_o <= '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/surf5_bus_pkg.sv
`default_nettype none

package surf5_bus_pkg;

    // Bus widths
    typedef logic [31:0] wb_word_t;
    typedef logic [15:0] wb_addr_t;

    // Register index from address bits 5:2
    typedef logic [3:0] reg_index_t;

    // Master side of the WISHBONE slave port
    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_addr_t adr;
        wb_word_t dat;
    } wb_req_t;

    // Slave response
    typedef struct packed {
        wb_word_t dat;
        logic     ack;
    } wb_rsp_t;

    // One strobe per writable register, plus the write data
    typedef struct packed {
        logic     int_sr;
        logic     int_mask;
        logic     reset;
        logic     led;
        logic     clocksel;
        logic     spiss;
        wb_word_t wdat;
    } reg_wr_t;

    ////////////////////////////////////////////////////////////////////
    // Address map, in word indexes
    ////////////////////////////////////////////////////////////////////
    localparam reg_index_t REG_DEVICE_ID = 4'd0;
    localparam reg_index_t REG_VERSION   = 4'd1;
    localparam reg_index_t REG_INT_SR    = 4'd2;
    localparam reg_index_t REG_INT_MASK  = 4'd3;
    localparam reg_index_t REG_RESET     = 4'd5;
    localparam reg_index_t REG_LED       = 4'd6;
    localparam reg_index_t REG_CLOCKSEL  = 4'd7;
    localparam reg_index_t REG_SPISS     = 4'd9;

    // ASCII 'S5A7'
    localparam wb_word_t DEVICE_ID = 32'h5335_4137;

endpackage

`default_nettype wire

//--- verilog/surf5_id_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module surf5_id_ctrl #(
    parameter surf5_bus_pkg::wb_word_t FIRMWARE_VERSION = '0,
    parameter int unsigned             SLOT_DWELL       = 1
) (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  surf5_bus_pkg::wb_req_t    bus_i,
    output surf5_bus_pkg::wb_rsp_t    bus_o,
    input  surf5_bus_pkg::wb_word_t   interrupt_i,
    input  surf5_led_pkg::led_vec_t   internal_led_i,
    output logic                      irq_o,
    output logic                      soft_rst_o,
    output logic                      sst_sel_o,
    output logic                      sst_sel_oe_o,
    output logic                      local_osc_en_o,
    output logic                      cs_b_o,
    output logic                      fp_led_o,
    output surf5_led_pkg::led_pins_t  led_pin_o,
    output surf5_led_pkg::led_pins_t  led_pin_oe_o
);

    // Write strobes and readback words
    surf5_bus_pkg::reg_wr_t   wr;
    surf5_bus_pkg::wb_word_t  int_sr;
    surf5_bus_pkg::wb_word_t  int_mask;
    surf5_bus_pkg::wb_word_t  led_word;
    surf5_led_pkg::led_vec_t  led_state;

    surf5_reg_decode #(
        .FIRMWARE_VERSION(FIRMWARE_VERSION)
    ) u_reg_decode (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .bus_i          (bus_i),
        .bus_o          (bus_o),
        .wr_o           (wr),
        .int_sr_i       (int_sr),
        .int_mask_i     (int_mask),
        .led_word_i     (led_word),
        .soft_rst_o     (soft_rst_o),
        .sst_sel_o      (sst_sel_o),
        .sst_sel_oe_o   (sst_sel_oe_o),
        .local_osc_en_o (local_osc_en_o),
        .cs_b_o         (cs_b_o)
    );

    surf5_irq_regs u_irq_regs (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_i        (wr),
        .interrupt_i (interrupt_i),
        .int_sr_o    (int_sr),
        .int_mask_o  (int_mask),
        .irq_o       (irq_o)
    );

    surf5_led_regs u_led_regs (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .wr_i           (wr),
        .internal_led_i (internal_led_i),
        .led_word_o     (led_word),
        .led_state_o    (led_state),
        .fp_led_o       (fp_led_o)
    );

    led_charlieplexer #(
        .SLOT_DWELL(SLOT_DWELL)
    ) u_led_charlieplexer (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .led_state_i  (led_state),
        .led_pin_o    (led_pin_o),
        .led_pin_oe_o (led_pin_oe_o)
    );

endmodule

`default_nettype wire

//--- verilog/surf5_irq_regs.sv
`timescale 1ns/1ps
`default_nettype none

module surf5_irq_regs (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  surf5_bus_pkg::reg_wr_t   wr_i,
    input  surf5_bus_pkg::wb_word_t  interrupt_i,
    output surf5_bus_pkg::wb_word_t  int_sr_o,
    output surf5_bus_pkg::wb_word_t  int_mask_o,
    output logic                     irq_o
);

    surf5_bus_pkg::wb_word_t int_sr_q;
    surf5_bus_pkg::wb_word_t int_mask_q;

    // Status tracks the inputs every cycle
    // Write of 1 clears that bit for the write cycle only
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            int_sr_q <= '0;
        end else if (wr_i.int_sr) begin
            int_sr_q <= int_sr_q & ~wr_i.wdat;
        end else begin
            int_sr_q <= interrupt_i;
        end
    end

    // Mask, 1 blocks the source
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            int_mask_q <= '0;
        end else if (wr_i.int_mask) begin
            int_mask_q <= wr_i.wdat;
        end
    end

    assign int_sr_o   = int_sr_q;
    assign int_mask_o = int_mask_q;

    // Any unmasked pending source
    assign irq_o = |(int_sr_q & ~int_mask_q);

endmodule

`default_nettype wire

//--- verilog/surf5_led_pkg.sv
`default_nettype none

package surf5_led_pkg;

    // One bit per LED, 0-5 green, 6-11 red
    typedef logic [11:0] led_vec_t;

    // One bit per charlieplex pin
    typedef logic [3:0] led_pins_t;

    // Scan slot number
    typedef logic [3:0] slot_t;

    localparam int LED_SLOTS = 12;

    ////////////////////////////////////////////////////////////////////
    // Charlieplex slot table
    ////////////////////////////////////////////////////////////////////
    // Pins driven high, per slot
    // Pairs 0-1, 0-2, 1-2, 2-3, 1-3, 0-3, then same pairs reversed
    localparam logic [1:0] LED_SLOT_HI [LED_SLOTS] = '{
        2'd0, 2'd0, 2'd1, 2'd2, 2'd1, 2'd0,
        2'd1, 2'd2, 2'd2, 2'd3, 2'd3, 2'd3
    };

    // Pins driven low, per slot
    localparam logic [1:0] LED_SLOT_LO [LED_SLOTS] = '{
        2'd1, 2'd2, 2'd2, 2'd3, 2'd3, 2'd3,
        2'd0, 2'd0, 2'd1, 2'd2, 2'd1, 2'd0
    };

endpackage

`default_nettype wire

//--- verilog/surf5_led_regs.sv
`timescale 1ns/1ps
`default_nettype none

module surf5_led_regs (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  surf5_bus_pkg::reg_wr_t   wr_i,
    input  surf5_led_pkg::led_vec_t  internal_led_i,
    output surf5_bus_pkg::wb_word_t  led_word_o,
    output surf5_led_pkg::led_vec_t  led_state_o,
    output logic                     fp_led_o
);

    surf5_bus_pkg::wb_word_t led_q;
    surf5_led_pkg::led_vec_t wr_ovr;
    surf5_led_pkg::led_vec_t held_ovr;

    // Override mask, bit 16+n covers LED n
    assign wr_ovr   = wr_i.wdat[27:16];
    assign held_ovr = led_q[27:16];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            led_q <= '0;
        end else if (wr_i.led) begin
            led_q[31:12] <= wr_i.wdat[31:12];
            // Written value where overridden, live LED elsewhere
            led_q[11:0]  <= (wr_i.wdat[11:0] & wr_ovr) | (internal_led_i & ~wr_ovr);
        end else begin
            // Sticky capture on free-running LEDs
            led_q[11:0] <= led_q[11:0] | (internal_led_i & ~held_ovr);
        end
    end

    assign led_word_o  = led_q;
    assign led_state_o = led_q[11:0];

    // Front panel LED
    assign fp_led_o = led_q[12];

endmodule

`default_nettype wire

//--- verilog/surf5_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module surf5_reg_decode #(
    parameter surf5_bus_pkg::wb_word_t FIRMWARE_VERSION = '0
) (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  surf5_bus_pkg::wb_req_t   bus_i,
    output surf5_bus_pkg::wb_rsp_t   bus_o,
    output surf5_bus_pkg::reg_wr_t   wr_o,
    input  surf5_bus_pkg::wb_word_t  int_sr_i,
    input  surf5_bus_pkg::wb_word_t  int_mask_i,
    input  surf5_bus_pkg::wb_word_t  led_word_i,
    output logic                     soft_rst_o,
    output logic                     sst_sel_o,
    output logic                     sst_sel_oe_o,
    output logic                     local_osc_en_o,
    output logic                     cs_b_o
);

    surf5_bus_pkg::reg_index_t idx;
    logic                      ack_q;
    logic                      wr_cycle;
    surf5_bus_pkg::wb_word_t   rd_dat;
    surf5_bus_pkg::wb_word_t   reset_q;
    surf5_bus_pkg::wb_word_t   clocksel_q;
    surf5_bus_pkg::wb_word_t   spiss_q;

    // Only bits 5:2 select a register
    assign idx = bus_i.adr[5:2];

    //////////////////////////////////////////////////////////////////////
    // Acknowledge
    //////////////////////////////////////////////////////////////////////
    // One cycle after cyc&stb, never two in a row
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus_i.cyc && bus_i.stb && !ack_q;
        end
    end

    // Dropped cyc kills the ack
    assign bus_o.ack = ack_q && bus_i.cyc;

    // Writes land at the end of the ack cycle
    assign wr_cycle = bus_o.ack && bus_i.we;

    //////////////////////////////////////////////////////////////////////
    // Write strobes
    //////////////////////////////////////////////////////////////////////
    assign wr_o.int_sr   = wr_cycle && (idx == surf5_bus_pkg::REG_INT_SR);
    assign wr_o.int_mask = wr_cycle && (idx == surf5_bus_pkg::REG_INT_MASK);
    assign wr_o.reset    = wr_cycle && (idx == surf5_bus_pkg::REG_RESET);
    assign wr_o.led      = wr_cycle && (idx == surf5_bus_pkg::REG_LED);
    assign wr_o.clocksel = wr_cycle && (idx == surf5_bus_pkg::REG_CLOCKSEL);
    assign wr_o.spiss    = wr_cycle && (idx == surf5_bus_pkg::REG_SPISS);
    assign wr_o.wdat     = bus_i.dat;

    // Local control registers, written whole
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            reset_q    <= '0;
            clocksel_q <= '0;
            spiss_q    <= '0;
        end else begin
            if (wr_o.reset) begin
                reset_q <= bus_i.dat;
            end
            if (wr_o.clocksel) begin
                clocksel_q <= bus_i.dat;
            end
            if (wr_o.spiss) begin
                spiss_q <= bus_i.dat;
            end
        end
    end

    // Board pins
    assign soft_rst_o     = reset_q[0];
    assign sst_sel_o      = clocksel_q[0];
    // Tristate enable for the SST select pin
    assign sst_sel_oe_o   = clocksel_q[1];
    assign local_osc_en_o = clocksel_q[2];
    // Flash chip select is active low
    assign cs_b_o         = ~spiss_q[0];

    //////////////////////////////////////////////////////////////////////
    // Read mux
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (idx)
            surf5_bus_pkg::REG_DEVICE_ID: rd_dat = surf5_bus_pkg::DEVICE_ID;
            surf5_bus_pkg::REG_VERSION:   rd_dat = FIRMWARE_VERSION;
            surf5_bus_pkg::REG_INT_SR:    rd_dat = int_sr_i;
            surf5_bus_pkg::REG_INT_MASK:  rd_dat = int_mask_i;
            surf5_bus_pkg::REG_RESET:     rd_dat = reset_q;
            surf5_bus_pkg::REG_LED:       rd_dat = led_word_i;
            surf5_bus_pkg::REG_CLOCKSEL:  rd_dat = clocksel_q;
            surf5_bus_pkg::REG_SPISS:     rd_dat = spiss_q;
            // Unmapped slots read zero
            default:                      rd_dat = '0;
        endcase
    end

    assign bus_o.dat = rd_dat;

endmodule

`default_nettype wire
